/* logic/mmuPkg.sv */
/*
 * MMU address and page definitions
 *  - address, vpn2, asid, pfn, cache attribute and TLB index types
 *  - joint TLB entry struct holding an even/odd page pair
 *  - TLB size, page geometry, segment bounds, cacheable attribute code
 */
`default_nettype none

package mmuPkg;

    localparam int TlbEntries     = 16;
    localparam int PageOffsetBits = 12;
    localparam int OddPageBit     = 12;  // picks the page within a pair

    typedef logic [31:0] vaddrT;
    typedef logic [31:0] paddrT;
    typedef logic [18:0] vpn2T;          // vaddr[31:13]
    typedef logic [7:0]  asidT;
    typedef logic [19:0] pfnT;
    typedef logic [2:0]  cacheAttrT;
    typedef logic [$clog2(TlbEntries)-1:0] tlbIndexT;

    localparam cacheAttrT CacheableAttr = 3'd3;

    // unmapped windows, kseg0 cached and kseg1 uncached
    localparam vaddrT Kseg0Base = 32'h8000_0000;
    localparam vaddrT Kseg1Base = 32'hA000_0000;
    localparam vaddrT Kseg2Base = 32'hC000_0000;

    // one TLB entry maps an even and an odd page
    typedef struct packed {
        vpn2T      vpn2;
        asidT      asid;
        logic      g;      // global, asid ignored
        pfnT       pfn0;
        cacheAttrT c0;
        logic      d0;     // dirty, page writable
        logic      v0;
        pfnT       pfn1;
        cacheAttrT c1;
        logic      d1;
        logic      v1;
    } tlbEntryT;

endpackage

`default_nettype wire

/* logic/accessPkg.sv */
/*
 * Memory access and CP0 interface definitions
 *  - load/store request kinds
 *  - TLB exception flags of a data access
 *  - CP0 TLB register select and data word
 */
`default_nettype none

package accessPkg;

    typedef logic [31:0] wordT;

    typedef struct packed {
        logic read;
        logic write;
    } memAccessT;

    typedef struct packed {
        logic refillRd;
        logic invalidRd;
        logic refillWr;
        logic invalidWr;
        logic modified;    // store to a clean page
    } tlbExcT;

    typedef enum logic [1:0] {
        SelIndex    = 2'd0,
        SelEntryHi  = 2'd1,
        SelEntryLo0 = 2'd2,
        SelEntryLo1 = 2'd3
    } cp0SelT;

endpackage

`default_nettype wire

/* logic/cp0TlbRegs.sv */
/*
 * CP0 TLB registers: Index, EntryHi, EntryLo0, EntryLo1
 *  - register write and combinational read
 *  - Index update from TLBP
 *  - assembly of the entry written by TLBWI
 */
`default_nettype none
`timescale 1ns/1ps

module cp0TlbRegs (
    input  logic                clk,
    input  logic                rstN,
    input  logic                cp0WrEn,
    input  accessPkg::cp0SelT   cp0Sel,
    input  accessPkg::wordT     cp0WrData,
    input  accessPkg::cp0SelT   cp0RdSel,
    input  logic                tlbProbe,
    input  logic                probeFound,
    input  mmuPkg::tlbIndexT    probeIndex,
    output accessPkg::wordT     cp0RdData,
    output mmuPkg::tlbEntryT    wrEntry,
    output mmuPkg::tlbIndexT    wrIndex,
    output mmuPkg::vpn2T        curVpn2,
    output mmuPkg::asidT        curAsid
);

    // EntryLo layout, bits 25..0 of the register
    typedef struct packed {
        mmuPkg::pfnT      pfn;
        mmuPkg::cacheAttrT c;
        logic             d;
        logic             v;
        logic             g;
    } entryLoT;

    logic             indexP;     // probe failure flag
    mmuPkg::tlbIndexT indexVal;
    mmuPkg::vpn2T     hiVpn2;
    mmuPkg::asidT     hiAsid;
    entryLoT          lo0;
    entryLoT          lo1;

    // P is only changed by TLBP
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            indexP   <= 1'b0;
            indexVal <= '0;
        end else if (tlbProbe) begin
            indexP <= !probeFound;
            if (probeFound) indexVal <= probeIndex;
        end else if (cp0WrEn && cp0Sel == accessPkg::SelIndex) begin
            indexVal <= cp0WrData[3:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiVpn2 <= '0;
            hiAsid <= '0;
            lo0    <= '0;
            lo1    <= '0;
        end else if (cp0WrEn) begin
            case (cp0Sel)
                accessPkg::SelEntryHi: begin
                    hiVpn2 <= cp0WrData[31:13];
                    hiAsid <= cp0WrData[7:0];
                end
                accessPkg::SelEntryLo0: lo0 <= cp0WrData[25:0];
                accessPkg::SelEntryLo1: lo1 <= cp0WrData[25:0];
                default: ;                 // Index handled above
            endcase
        end
    end

    always_comb begin
        cp0RdData = '0;
        case (cp0RdSel)
            accessPkg::SelIndex:    cp0RdData = {indexP, 27'h0, indexVal};
            accessPkg::SelEntryHi:  cp0RdData = {hiVpn2, 5'h0, hiAsid};
            accessPkg::SelEntryLo0: cp0RdData = {6'h0, lo0};
            accessPkg::SelEntryLo1: cp0RdData = {6'h0, lo1};
            default:                cp0RdData = '0;
        endcase
    end

    // g of the pair is the AND of both halves
    assign wrEntry = '{vpn2: hiVpn2, asid: hiAsid, g: lo0.g & lo1.g,
                       pfn0: lo0.pfn, c0: lo0.c, d0: lo0.d, v0: lo0.v,
                       pfn1: lo1.pfn, c1: lo1.c, d1: lo1.d, v1: lo1.v};
    assign wrIndex = indexVal;
    assign curVpn2 = hiVpn2;
    assign curAsid = hiAsid;

    // software must not write Index while a probe result lands
    probeIndexWr: assert property (@(posedge clk) disable iff (!rstN)
        !(tlbProbe && cp0WrEn && cp0Sel == accessPkg::SelIndex));

endmodule

`default_nettype wire

/* logic/tlbArray.sv */
/*
 * Joint TLB of 16 entries
 *  - write port driven by TLBWI
 *  - refill search port for the micro-TLB, vpn2 match only
 *  - probe search port for TLBP, vpn2 and asid/global match
 */
`default_nettype none
`timescale 1ns/1ps

module tlbArray (
    input  logic             clk,
    input  logic             rstN,
    input  logic             tlbWrite,
    input  mmuPkg::tlbIndexT wrIndex,
    input  mmuPkg::tlbEntryT wrEntry,
    input  mmuPkg::vpn2T     refillVpn2,
    input  mmuPkg::vpn2T     probeVpn2,
    input  mmuPkg::asidT     probeAsid,
    output logic             refillFound,
    output mmuPkg::tlbEntryT refillEntry,
    output logic             probeFound,
    output mmuPkg::tlbIndexT probeIndex
);

    mmuPkg::tlbEntryT                entries [mmuPkg::TlbEntries];
    logic [mmuPkg::TlbEntries-1:0]   entryUsed;   // written since reset
    logic [mmuPkg::TlbEntries-1:0]   refillHit;
    logic [mmuPkg::TlbEntries-1:0]   probeHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entries   <= '{default: '0};
            entryUsed <= '0;
        end else if (tlbWrite) begin
            entries[wrIndex]   <= wrEntry;
            entryUsed[wrIndex] <= 1'b1;
        end
    end

    // per-entry compare
    always_comb begin
        for (int i = 0; i < mmuPkg::TlbEntries; i++) begin
            // asid is left to the translator for refills
            refillHit[i] = entryUsed[i] && entries[i].vpn2 == refillVpn2;
            probeHit[i]  = entryUsed[i] && entries[i].vpn2 == probeVpn2
                           && (entries[i].g || entries[i].asid == probeAsid);
        end
    end

    // walk downwards so the lowest hit is the one kept
    always_comb begin
        refillFound = 1'b0;
        refillEntry = entries[0];
        probeFound  = 1'b0;
        probeIndex  = '0;
        for (int i = mmuPkg::TlbEntries - 1; i >= 0; i--) begin
            if (refillHit[i]) begin
                refillFound = 1'b1;
                refillEntry = entries[i];
            end
            if (probeHit[i]) begin
                probeFound = 1'b1;
                probeIndex = mmuPkg::tlbIndexT'(i);
            end
        end
    end

    // duplicate mappings for the current EntryHi are a software error
    probeUnique: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(probeHit));

endmodule

`default_nettype wire

/* logic/microTlb.sv */
/*
 * One-entry data micro-TLB
 *  - buffered entry with tag, valid and inTlb flags
 *  - IDLE/REFILL FSM that stalls on a tag miss of a mapped address
 *  - flushed by TLBWI
 */
`default_nettype none
`timescale 1ns/1ps

module microTlb (
    input  logic             clk,
    input  logic             rstN,
    input  mmuPkg::vpn2T     vpn2,
    input  logic             tlbWrite,
    input  logic             foundIn,
    input  mmuPkg::tlbEntryT entryIn,
    output mmuPkg::tlbEntryT bufEntry,
    output logic             bufInTlb,
    output logic             tagHit,
    output logic             stall,
    output mmuPkg::vpn2T     refillVpn2
);

    typedef enum logic {Idle, Refill} stateT;

    stateT         state;
    stateT         stateNext;
    logic          bufValid;
    mmuPkg::vpn2T  bufTag;       // vpn2 that was searched
    mmuPkg::vaddrT pairBase;
    logic          mapped;
    logic          needRefill;

    assign pairBase = {vpn2, {(mmuPkg::OddPageBit + 1){1'b0}}};
    // kseg0/kseg1 never need the buffer
    assign mapped   = pairBase < mmuPkg::Kseg0Base || pairBase >= mmuPkg::Kseg2Base;

    assign tagHit     = bufValid && bufTag == vpn2;
    assign needRefill = mapped && !tagHit;
    assign stall      = needRefill;   // held through REFILL too
    assign refillVpn2 = vpn2;

    always_comb begin
        stateNext = state;
        case (state)
            Idle:    if (needRefill) stateNext = Refill;
            Refill:  stateNext = Idle;   // search result is ready by now
            default: stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= Idle;
            bufValid <= 1'b0;
            bufInTlb <= 1'b0;
        end else begin
            state <= stateNext;
            if (tlbWrite) begin          // TLBWI flush wins
                bufValid <= 1'b0;
                bufInTlb <= 1'b0;
            end else if (state == Refill) begin
                bufValid <= 1'b1;
                bufInTlb <= foundIn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == Refill) begin
            bufTag   <= refillVpn2;
            bufEntry <= entryIn;
        end
    end

    // a steady address hits right after its refill
    hitAfterRefill: assert property (@(posedge clk) disable iff (!rstN)
        state == Refill && !tlbWrite |=> !$stable(vpn2) || !stall);

endmodule

`default_nettype wire

/* logic/addrTranslate.sv */
/*
 * Data address translation
 *  - kseg0/kseg1 fixed mapping
 *  - even/odd page select, physical address and cache attribute
 *  - access valid and TLB exception classification
 */
`default_nettype none
`timescale 1ns/1ps

module addrTranslate (
    input  mmuPkg::vaddrT        vaddr,
    input  accessPkg::memAccessT access,
    input  mmuPkg::tlbEntryT     bufEntry,
    input  logic                 bufInTlb,
    input  logic                 tagHit,
    input  mmuPkg::asidT         curAsid,
    output mmuPkg::paddrT        paddr,
    output logic                 cached,
    output logic                 addrValid,
    output accessPkg::tlbExcT    exc
);

    logic              oddPage;
    mmuPkg::pfnT       pagePfn;
    mmuPkg::cacheAttrT pageC;
    logic              pageD;
    logic              pageV;
    logic              inKseg0;
    logic              inKseg1;
    logic              asidOk;
    logic              anyAccess;

    assign oddPage = vaddr[mmuPkg::OddPageBit];

    // half of the pair selected by the odd page bit
    assign pagePfn = oddPage ? bufEntry.pfn1 : bufEntry.pfn0;
    assign pageC   = oddPage ? bufEntry.c1   : bufEntry.c0;
    assign pageD   = oddPage ? bufEntry.d1   : bufEntry.d0;
    assign pageV   = oddPage ? bufEntry.v1   : bufEntry.v0;

    assign inKseg1 = vaddr >= mmuPkg::Kseg1Base && vaddr < mmuPkg::Kseg2Base;
    assign inKseg0 = vaddr >= mmuPkg::Kseg0Base && vaddr < mmuPkg::Kseg1Base;

    assign asidOk    = bufEntry.g || bufEntry.asid == curAsid;
    assign anyAccess = access.read || access.write;

    always_comb begin
        paddr     = {pagePfn, vaddr[mmuPkg::PageOffsetBits-1:0]};
        cached    = pageC == mmuPkg::CacheableAttr;
        addrValid = 1'b0;
        exc       = '0;
        if (inKseg1) begin
            paddr     = vaddr - mmuPkg::Kseg1Base;
            cached    = 1'b0;
            addrValid = 1'b1;
        end else if (inKseg0) begin
            paddr     = vaddr - mmuPkg::Kseg0Base;
            cached    = 1'b1;
            addrValid = 1'b1;
        end else if (!tagHit) begin
            addrValid = 1'b0;                  // refill in progress
        end else if (!anyAccess) begin
            addrValid = 1'b0;
        end else if (!bufInTlb || !asidOk) begin
            // no mapping for this asid
            if (access.read) exc.refillRd = 1'b1;
            else             exc.refillWr = 1'b1;
        end else if (!pageV) begin
            if (access.read) exc.invalidRd = 1'b1;
            else             exc.invalidWr = 1'b1;
        end else if (access.write && !pageD) begin
            exc.modified = 1'b1;               // store to clean page
        end else begin
            addrValid = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/dataMmu.sv */
/*
 * Data-side MMU top
 *  - CP0 TLB registers, joint TLB, micro-TLB and address translator
 */
`default_nettype none
`timescale 1ns/1ps

module dataMmu (
    input  logic                 clk,
    input  logic                 rstN,
    input  mmuPkg::vaddrT        vaddr,
    input  accessPkg::memAccessT access,
    input  logic                 cp0WrEn,
    input  accessPkg::cp0SelT    cp0Sel,
    input  accessPkg::wordT      cp0WrData,
    input  accessPkg::cp0SelT    cp0RdSel,
    input  logic                 tlbWrite,    // TLBWI
    input  logic                 tlbProbe,    // TLBP
    output accessPkg::wordT      cp0RdData,
    output mmuPkg::paddrT        paddr,
    output logic                 cached,
    output logic                 addrValid,
    output logic                 stall,
    output accessPkg::tlbExcT    exc
);

    mmuPkg::tlbEntryT wrEntry;
    mmuPkg::tlbIndexT wrIndex;
    mmuPkg::vpn2T     curVpn2;
    mmuPkg::asidT     curAsid;
    logic             probeFound;
    mmuPkg::tlbIndexT probeIndex;
    mmuPkg::vpn2T     refillVpn2;
    logic             refillFound;
    mmuPkg::tlbEntryT refillEntry;
    mmuPkg::tlbEntryT bufEntry;
    logic             bufInTlb;
    logic             tagHit;

    cp0TlbRegs i_cp0TlbRegs (
        .clk        (clk),
        .rstN       (rstN),
        .cp0WrEn    (cp0WrEn),
        .cp0Sel     (cp0Sel),
        .cp0WrData  (cp0WrData),
        .cp0RdSel   (cp0RdSel),
        .tlbProbe   (tlbProbe),
        .probeFound (probeFound),
        .probeIndex (probeIndex),
        .cp0RdData  (cp0RdData),
        .wrEntry    (wrEntry),
        .wrIndex    (wrIndex),
        .curVpn2    (curVpn2),
        .curAsid    (curAsid)
    );

    tlbArray i_tlbArray (
        .clk         (clk),
        .rstN        (rstN),
        .tlbWrite    (tlbWrite),
        .wrIndex     (wrIndex),
        .wrEntry     (wrEntry),
        .refillVpn2  (refillVpn2),
        .probeVpn2   (curVpn2),     // TLBP searches EntryHi
        .probeAsid   (curAsid),
        .refillFound (refillFound),
        .refillEntry (refillEntry),
        .probeFound  (probeFound),
        .probeIndex  (probeIndex)
    );

    microTlb i_microTlb (
        .clk        (clk),
        .rstN       (rstN),
        .vpn2       (vaddr[31:mmuPkg::OddPageBit+1]),
        .tlbWrite   (tlbWrite),
        .foundIn    (refillFound),
        .entryIn    (refillEntry),
        .bufEntry   (bufEntry),
        .bufInTlb   (bufInTlb),
        .tagHit     (tagHit),
        .stall      (stall),
        .refillVpn2 (refillVpn2)
    );

    addrTranslate i_addrTranslate (
        .vaddr     (vaddr),
        .access    (access),
        .bufEntry  (bufEntry),
        .bufInTlb  (bufInTlb),
        .tagHit    (tagHit),
        .curAsid   (curAsid),
        .paddr     (paddr),
        .cached    (cached),
        .addrValid (addrValid),
        .exc       (exc)
    );

endmodule

`default_nettype wire

/* verif/tbDataMmu.sv */
/*
 * Testbench for the data-side MMU
 *  - clock, reset and CP0 / TLBWI / TLBP stimulus
 *  - model of the TLB and CP0 registers with a reference translation
 *  - compare process and value check
 */
`default_nettype none
`timescale 1ns/1ps

module tbDataMmu;

    localparam logic [31:0] Seed       = 32'h504860cd;
    localparam logic [31:0] Kseg0Start = 32'h8000_0000;
    localparam logic [31:0] Kseg1Start = 32'hA000_0000;
    localparam logic [31:0] Kseg2Start = 32'hC000_0000;
    localparam int          StallLimit = 20;    // cycles
    localparam int          CheckLimit = 20;    // ns

    typedef struct packed {
        mmuPkg::paddrT     paddr;
        logic              cached;
        logic              addrValid;
        accessPkg::tlbExcT exc;
        logic              pageKnown;  // paddr and cached are defined
    } resultT;

    logic                 clk;
    logic                 rstN;
    mmuPkg::vaddrT        vaddr;
    accessPkg::memAccessT access;
    logic                 cp0WrEn;
    accessPkg::cp0SelT    cp0Sel;
    accessPkg::wordT      cp0WrData;
    accessPkg::cp0SelT    cp0RdSel;
    logic                 tlbWrite;
    logic                 tlbProbe;
    accessPkg::wordT      cp0RdData;
    mmuPkg::paddrT        paddr;
    logic                 cached;
    logic                 addrValid;
    logic                 stall;
    accessPkg::tlbExcT    exc;

    // model state
    mmuPkg::tlbEntryT     modelTlb [16];
    logic [15:0]          modelUsed;
    logic                 modelP;
    mmuPkg::tlbIndexT     modelIndex;
    mmuPkg::vpn2T         modelVpn2;
    mmuPkg::asidT         modelAsid;
    accessPkg::wordT      modelLo0;
    accessPkg::wordT      modelLo1;
    logic                 modelBufValid;   // micro-TLB holds a mapped pair
    mmuPkg::vpn2T         modelBufVpn2;

    logic                 checkReq;
    logic                 checkDone = 1'b0;
    int                   errorCount = 0;

    dataMmu i_dataMmu (
        .clk       (clk),
        .rstN      (rstN),
        .vaddr     (vaddr),
        .access    (access),
        .cp0WrEn   (cp0WrEn),
        .cp0Sel    (cp0Sel),
        .cp0WrData (cp0WrData),
        .cp0RdSel  (cp0RdSel),
        .tlbWrite  (tlbWrite),
        .tlbProbe  (tlbProbe),
        .cp0RdData (cp0RdData),
        .paddr     (paddr),
        .cached    (cached),
        .addrValid (addrValid),
        .stall     (stall),
        .exc       (exc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            stopWithError($sformatf("FAILED %s: actual 0x%h expected 0x%h",
                                    name, actual, expected));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic accessPkg::wordT makeLo(input mmuPkg::pfnT pfn,
            input mmuPkg::cacheAttrT c, input logic d, input logic v, input logic g);
        return {6'h0, pfn, c, d, v, g};
    endfunction

    function automatic accessPkg::wordT makeHi(input mmuPkg::vpn2T vpn2,
                                               input mmuPkg::asidT asid);
        return {vpn2, 5'h0, asid};
    endfunction

    // valid, dirty page with a random frame, cacheable or not
    function automatic accessPkg::wordT randomLo(input logic g);
        logic [31:0] rnd;
        rnd = $urandom;
        return makeLo(rnd[19:0], rnd[20] ? 3'd3 : 3'd2, 1'b1, 1'b1, g);
    endfunction

    function automatic mmuPkg::vaddrT pageAddr(input mmuPkg::vpn2T vpn2,
                                               input logic odd, input logic [11:0] offset);
        return {vpn2, odd, offset};
    endfunction

    // expected outputs from the segment and exception rules
    function automatic resultT expectedResult(input mmuPkg::vaddrT va,
                                              input accessPkg::memAccessT acc);
        resultT           r;
        logic             found;
        mmuPkg::tlbEntryT e;
        logic             odd;
        logic             pageV;
        logic             pageD;
        r = '0;
        found = 1'b0;
        e = '0;
        if (va >= Kseg1Start && va < Kseg2Start) begin
            r.paddr = va - Kseg1Start;
            r.addrValid = 1'b1;
            r.pageKnown = 1'b1;
            return r;
        end
        if (va >= Kseg0Start && va < Kseg1Start) begin
            r.paddr = va - Kseg0Start;
            r.cached = 1'b1;
            r.addrValid = 1'b1;
            r.pageKnown = 1'b1;
            return r;
        end
        for (int i = 0; i < 16; i++) begin
            if (!found && modelUsed[i] && modelTlb[i].vpn2 == va[31:13]) begin
                found = 1'b1;
                e = modelTlb[i];
            end
        end
        odd = va[12];
        pageV = odd ? e.v1 : e.v0;
        pageD = odd ? e.d1 : e.d0;
        r.pageKnown = found;
        r.paddr = {odd ? e.pfn1 : e.pfn0, va[11:0]};
        r.cached = (odd ? e.c1 : e.c0) == 3'd3;
        if (!acc.read && !acc.write) return r;
        if (!found || !(e.g || e.asid == modelAsid)) begin
            if (acc.read) r.exc.refillRd = 1'b1;
            else          r.exc.refillWr = 1'b1;
        end else if (!pageV) begin
            if (acc.read) r.exc.invalidRd = 1'b1;
            else          r.exc.invalidWr = 1'b1;
        end else if (acc.write && !pageD) begin
            r.exc.modified = 1'b1;
        end else begin
            r.addrValid = 1'b1;
        end
        return r;
    endfunction

    function automatic accessPkg::wordT expectedCp0(input accessPkg::cp0SelT sel);
        case (sel)
            accessPkg::SelIndex:    return {modelP, 27'h0, modelIndex};
            accessPkg::SelEntryHi:  return {modelVpn2, 5'h0, modelAsid};
            accessPkg::SelEntryLo0: return {6'h0, modelLo0[25:0]};
            default:                return {6'h0, modelLo1[25:0]};
        endcase
    endfunction

    task automatic writeCp0(input accessPkg::cp0SelT sel, input accessPkg::wordT data);
        cp0WrEn = 1'b1;
        cp0Sel = sel;
        cp0WrData = data;
        tick();
        cp0WrEn = 1'b0;
        case (sel)
            accessPkg::SelIndex: modelIndex = data[3:0];   // P untouched
            accessPkg::SelEntryHi: begin
                modelVpn2 = data[31:13];
                modelAsid = data[7:0];
            end
            accessPkg::SelEntryLo0: modelLo0 = data;
            default: modelLo1 = data;
        endcase
    endtask

    task automatic writeTlbEntry(input mmuPkg::tlbIndexT idx, input accessPkg::wordT hi,
                                 input accessPkg::wordT lo0, input accessPkg::wordT lo1);
        writeCp0(accessPkg::SelIndex, {28'h0, idx});
        writeCp0(accessPkg::SelEntryHi, hi);
        writeCp0(accessPkg::SelEntryLo0, lo0);
        writeCp0(accessPkg::SelEntryLo1, lo1);
        tlbWrite = 1'b1;
        tick();
        tlbWrite = 1'b0;
        modelTlb[modelIndex] = '{vpn2: modelVpn2, asid: modelAsid,
                                 g: modelLo0[0] & modelLo1[0],
                                 pfn0: modelLo0[25:6], c0: modelLo0[5:3],
                                 d0: modelLo0[2], v0: modelLo0[1],
                                 pfn1: modelLo1[25:6], c1: modelLo1[5:3],
                                 d1: modelLo1[2], v1: modelLo1[1]};
        modelUsed[modelIndex] = 1'b1;
        modelBufValid = 1'b0;   // TLBWI empties the micro-TLB
    endtask

    task automatic probeTlb();
        logic found;
        found = 1'b0;
        tlbProbe = 1'b1;
        tick();
        tlbProbe = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (!found && modelUsed[i] && modelTlb[i].vpn2 == modelVpn2
                    && (modelTlb[i].g || modelTlb[i].asid == modelAsid)) begin
                found = 1'b1;
                modelIndex = mmuPkg::tlbIndexT'(i);
            end
        end
        modelP = !found;
    endtask

    task automatic waitStallLow(input logic expStall);
        int cycles;
        cycles = 0;
        @(negedge clk);
        checkValue("stall", 32'(stall), 32'(expStall));
        while (stall) begin
            cycles++;
            if (cycles > StallLimit) stopWithError("timeout: stall did not fall after an access");
            @(negedge clk);
        end
    endtask

    task automatic accessAndCheck(input mmuPkg::vaddrT addr, input logic rd, input logic wr,
                                  input accessPkg::cp0SelT sel);
        int   waited;
        logic mapped;
        logic expStall;
        waited = 0;
        mapped = addr < Kseg0Start || addr >= Kseg2Start;
        // a mapped address stalls unless its pair is already buffered
        expStall = mapped && !(modelBufValid && modelBufVpn2 == addr[31:13]);
        vaddr = addr;
        access = '{read: rd, write: wr};
        cp0RdSel = sel;
        waitStallLow(expStall);
        checkReq = 1'b1;
        while (!checkDone) begin
            #1;
            waited++;
            if (waited > CheckLimit) stopWithError("timeout: compare process did not respond");
        end
        checkReq = 1'b0;
        if (mapped) begin
            modelBufValid = 1'b1;
            modelBufVpn2 = addr[31:13];
        end
        tick();
    endtask

    always begin : compareOutputs
        resultT expRes;
        @(posedge checkReq);
        expRes = expectedResult(vaddr, access);
        checkValue("addrValid", 32'(addrValid), 32'(expRes.addrValid));
        checkValue("exc", 32'(exc), 32'(expRes.exc));
        if (expRes.pageKnown) begin
            checkValue("paddr", paddr, expRes.paddr);
            checkValue("cached", 32'(cached), 32'(expRes.cached));
        end
        checkValue("cp0RdData", cp0RdData, expectedCp0(cp0RdSel));
        checkDone = 1'b1;
        @(negedge checkReq);
        checkDone = 1'b0;
    end

    initial begin : stimulus
        logic [31:0]  rnd;
        mmuPkg::vpn2T pairVpn2;
        void'($urandom(Seed));
        rstN = 1'b0;
        vaddr = '0;
        access = '0;
        cp0WrEn = 1'b0;
        cp0Sel = accessPkg::SelIndex;
        cp0WrData = '0;
        cp0RdSel = accessPkg::SelIndex;
        tlbWrite = 1'b0;
        tlbProbe = 1'b0;
        checkReq = 1'b0;
        modelUsed = '0;
        for (int i = 0; i < 16; i++) modelTlb[i] = '0;
        modelP = 1'b0;
        modelIndex = '0;
        modelVpn2 = '0;
        modelAsid = '0;
        modelLo0 = '0;
        modelLo1 = '0;
        modelBufValid = 1'b0;
        modelBufVpn2 = '0;
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;

        // unmapped kseg0/kseg1 windows
        for (int n = 0; n < 24; n++) begin
            rnd = $urandom;
            accessAndCheck(Kseg0Start + ($urandom % 32'h4000_0000), rnd[0], !rnd[0] && rnd[1],
                           accessPkg::cp0SelT'(rnd[3:2]));
        end

        // empty TLB right after reset
        accessAndCheck(32'h0040_1234, 1'b1, 1'b0, accessPkg::SelEntryHi);
        accessAndCheck(32'hC123_4567, 1'b0, 1'b1, accessPkg::SelIndex);
        accessAndCheck(32'h0040_3000, 1'b0, 1'b0, accessPkg::SelEntryLo0);

        // random mappings, even and odd pages
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            writeTlbEntry(mmuPkg::tlbIndexT'(i), makeHi({1'b0, rnd[13:0], 4'(i)}, 8'h11),
                          randomLo(rnd[20]), randomLo(rnd[20]));
        end
        for (int i = 0; i < 8; i++) begin
            for (int odd = 0; odd < 2; odd++) begin
                rnd = $urandom;
                accessAndCheck(pageAddr(modelTlb[i].vpn2, odd[0], rnd[11:0]), rnd[12], !rnd[12],
                               accessPkg::cp0SelT'(rnd[14:13]));
            end
        end

        // invalid even page, clean odd page
        pairVpn2 = {1'b0, 14'h1234, 4'h8};
        writeTlbEntry(4'd8, makeHi(pairVpn2, 8'h11), makeLo(20'h12345, 3'd3, 1'b1, 1'b0, 1'b0),
                      makeLo(20'h6789A, 3'd2, 1'b0, 1'b1, 1'b0));
        accessAndCheck(pageAddr(pairVpn2, 1'b0, 12'h010), 1'b1, 1'b0, accessPkg::SelEntryLo0);
        accessAndCheck(pageAddr(pairVpn2, 1'b0, 12'h020), 1'b0, 1'b1, accessPkg::SelEntryLo1);
        accessAndCheck(pageAddr(pairVpn2, 1'b1, 12'h030), 1'b0, 1'b1, accessPkg::SelEntryHi);
        accessAndCheck(pageAddr(pairVpn2, 1'b1, 12'h040), 1'b1, 1'b0, accessPkg::SelIndex);

        // asid change, private entry 9 and global entry 10
        writeTlbEntry(4'd9, makeHi({1'b0, 14'h0AAA, 4'h9}, 8'h11), randomLo(1'b0),
                      randomLo(1'b0));
        writeTlbEntry(4'd10, makeHi({1'b0, 14'h0555, 4'hA}, 8'h11), randomLo(1'b1),
                      randomLo(1'b1));
        writeCp0(accessPkg::SelEntryHi, makeHi(19'h0, 8'h22));
        accessAndCheck(pageAddr(modelTlb[9].vpn2, 1'b0, 12'h100), 1'b1, 1'b0,
                       accessPkg::SelEntryHi);
        accessAndCheck(pageAddr(modelTlb[9].vpn2, 1'b1, 12'h104), 1'b0, 1'b1,
                       accessPkg::SelEntryHi);
        accessAndCheck(pageAddr(modelTlb[10].vpn2, 1'b1, 12'h208), 1'b1, 1'b0,
                       accessPkg::SelIndex);
        // rewrite the buffered entry with new frames
        writeTlbEntry(4'd10, makeHi(modelTlb[10].vpn2, 8'h22),
                      makeLo(20'hFACE0, 3'd2, 1'b1, 1'b1, 1'b1),
                      makeLo(20'h0BEEF, 3'd3, 1'b1, 1'b1, 1'b1));
        accessAndCheck(pageAddr(modelTlb[10].vpn2, 1'b1, 12'h208), 1'b1, 1'b0,
                       accessPkg::SelEntryLo1);
        accessAndCheck(pageAddr(modelTlb[10].vpn2, 1'b0, 12'h20C), 1'b0, 1'b1,
                       accessPkg::SelEntryLo0);

        // TLBP hit on entry 5, then a miss
        writeCp0(accessPkg::SelEntryHi, makeHi(modelTlb[5].vpn2, 8'h11));
        probeTlb();
        accessAndCheck(Kseg1Start + 32'h100, 1'b1, 1'b0, accessPkg::SelIndex);
        writeCp0(accessPkg::SelEntryHi, makeHi({1'b0, 14'h0, 4'hF}, 8'h11));
        probeTlb();
        accessAndCheck(Kseg1Start + 32'h200, 1'b1, 1'b0, accessPkg::SelIndex);

        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/mmuPkg.sv
logic/accessPkg.sv
logic/cp0TlbRegs.sv
logic/tlbArray.sv
logic/microTlb.sv
logic/addrTranslate.sv
logic/dataMmu.sv
verif/tbDataMmu.sv

/* Makefile */
# Verilator build for the data-side MMU testbench

VERILATOR ?= verilator
TOP       ?= tbDataMmu
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
